// ==== src/dbg_pkg.sv ====
package dbg_pkg;

	typedef logic [7:0]  byte_t;       // one serial or host data byte
	typedef logic [23:0] host_addr_t;  // host bus byte address
	typedef logic [8:0]  count_t;      // bit 8 sets once the count runs below zero
	typedef logic [31:0] port_word_t;  // byte 3 is port 0 and byte 0 is port 3
	typedef logic [31:0] opcode_t;     // four ascii characters, first one in the msb

	localparam opcode_t op_read  = 32'h52656164;  // "Read" host memory to serial
	localparam opcode_t op_write = 32'h57726974;  // "Writ" serial to host memory with echo
	localparam opcode_t op_setp  = 32'h53657450;  // "SetP" set outputs and return inputs

	// ************************************************************************
	// frame preamble in front of the doubled command body
	// ************************************************************************
	localparam int pre_zero_cnt = 6;  // 0x00 bytes that open a frame
	localparam int pre_ff_cnt   = 2;  // 0xff bytes right after them

	typedef struct packed {
		opcode_t    op;     // first four body bytes
		host_addr_t addr;   // start address, msb arrives first
		byte_t      count;  // number of bytes minus one
	} dbg_cmd_t;

	typedef struct packed {
		logic       rd_req;  // one-cycle read strobe
		logic       wr_ena;  // one-cycle write strobe
		host_addr_t addr;
		byte_t      wdata;
	} host_req_t;

	typedef enum logic [1:0] {
		st_idle,   // waiting for a frame
		st_read,   // host memory to serial
		st_write,  // serial to host memory
		st_ports   // port bytes to serial
	} xfer_state_t;

endpackage

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import dbg_pkg::*; #(
	parameter int bit_clks = 54
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  rxd,
	output byte_t rx_data,
	output logic  rx_rdy,
	output logic  rx_trigger
);

	localparam int pw = $clog2(bit_clks);
	localparam logic [pw-1:0] period_max  = pw'(bit_clks - 1);        // reload value of the bit clock
	localparam logic [pw-1:0] period_half = pw'((bit_clks - 1) / 2);  // lands the samples mid bit

	logic          rxd_reg;      // first sync stage of the line
	logic          rxd_last;     // second stage, used for the edge detect
	logic          rx_busy;      // a byte is being received
	logic [pw-1:0] rx_period;    // counts down the cycles of one bit
	logic [3:0]    rx_position;  // samples left before the stop bit
	logic [8:0]    rx_shift;     // start bit and data, lsb first

	// a falling edge on an idle line is a start bit, the transmitter aligns to it too
	assign rx_trigger = ~rxd_reg & rxd_last & ~rx_busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			rxd_reg     <= 1'b1;  // line idles high
			rxd_last    <= 1'b1;
			rx_busy     <= 1'b0;
			rx_rdy      <= 1'b0;
			rx_period   <= '0;
			rx_position <= '0;
		end else begin
			rxd_reg  <= rxd;
			rxd_last <= rxd_reg;
			rx_rdy   <= 1'b0;  // single cycle pulse

			if (rx_trigger) begin
				rx_period   <= period_half;  // first sample half a bit after the edge
				rx_position <= 4'd9;         // start plus eight data bits, then the stop bit
				rx_busy     <= 1'b1;
			end else if (rx_period == '0) begin
				rx_period <= period_max;
				if (rx_position != '0) begin
					rx_position <= rx_position - 4'd1;
					rx_shift    <= {rxd_reg, rx_shift[8:1]};  // newest bit enters at the top
				end else if (rx_busy) begin
					// this is the stop bit sample, the byte sits above the start bit
					rx_data <= rx_shift[8:1];
					rx_rdy  <= 1'b1;
					rx_busy <= 1'b0;  // the next start edge may now be taken
				end
			end else begin
				rx_period <= rx_period - 1'b1;
			end
		end
	end

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import dbg_pkg::*; #(
	parameter int bit_clks = 54
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  tx_start,
	input  byte_t tx_data,
	input  logic  rx_trigger,
	output logic  txd,
	output logic  tx_busy
);

	localparam int pw = $clog2(bit_clks);
	localparam logic [pw-1:0] period_max  = pw'(bit_clks - 1);
	localparam logic [pw-1:0] period_half = pw'((bit_clks - 1) / 2);

	logic [pw-1:0] tx_period;    // bit clock, txd changes when it wraps
	logic [3:0]    tx_position;  // 0 is the start bit, then 9 down to 1 which is the stop bit
	logic [9:0]    tx_shift;     // framed byte, bit 0 goes out next
	byte_t         tx_data_reg;  // byte waiting for the next frame slot
	logic          tx_run;       // a start bit has gone out and the frame must not be cut

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_period   <= period_max;
			tx_position <= '0;
			tx_shift    <= '1;  // all stop bits keep the line idle
			tx_run      <= 1'b0;
			tx_busy     <= 1'b0;
			txd         <= 1'b1;
		end else begin
			// ************************************************************************
			// mid bit, prepare the shift register for the next edge
			// ************************************************************************
			if (tx_period == period_half) begin
				if (tx_position == 4'd1) begin
					tx_run <= 1'b0;  // from here on the bit clock may follow the receiver
					if (tx_busy) begin
						tx_shift <= {1'b1, tx_data_reg, 1'b0};  // stop, data, start
						tx_busy  <= 1'b0;
					end
				end else begin
					tx_shift <= {1'b1, tx_shift[9:1]};  // refill with idle bits
					if (tx_position == '0)
						tx_run <= ~txd;  // only a real start bit locks the timing
				end
			end

			// a new byte after the frame load above keeps its busy flag
			if (tx_start) begin
				tx_data_reg <= tx_data;
				tx_busy     <= 1'b1;
			end

			// ************************************************************************
			// bit edge, or re-alignment to an incoming start bit while not running
			// ************************************************************************
			if (rx_trigger && !tx_run) begin
				tx_period   <= period_max;
				tx_position <= '0;
				txd         <= tx_shift[0];  // start bit goes out with the host's one
			end else if (tx_period == '0) begin
				tx_period <= period_max;
				txd       <= tx_shift[0];
				if (tx_position == '0)
					tx_position <= 4'd9;
				else
					tx_position <= tx_position - 4'd1;
			end else begin
				tx_period <= tx_period - 1'b1;
			end
		end
	end

endmodule

// ==== src/cmd_detect.sv ====
`timescale 1ns/1ps

module cmd_detect import dbg_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  byte_t    rx_data,
	input  logic     rx_rdy,
	input  logic     idle,
	output dbg_cmd_t cmd,
	output logic     cmd_valid
);

	byte_t [15:0] win;           // receive window, slot 15 is the oldest byte
	logic  [1:0]  rdy_dly;       // rx_rdy pipeline, the byte lands three cycles after the pulse
	logic  [2:0]  zero_cnt;      // 0x00 bytes that left the window in a row
	logic  [2:0]  ff_cnt;        // 0xff bytes that left after them
	logic         halves_match;  // both body copies agree
	logic         op_known;      // first copy carries a supported opcode

	assign cmd          = dbg_cmd_t'(win[7:0]);  // newest copy of the body
	assign halves_match = (win[15:8] == win[7:0]);
	assign op_known     = (cmd.op == op_read) || (cmd.op == op_write) || (cmd.op == op_setp);

	// the window is flushed on the next edge so this stays a single cycle pulse
	assign cmd_valid = (zero_cnt == 3'(pre_zero_cnt)) && (ff_cnt == 3'(pre_ff_cnt)) &&
		halves_match && op_known;

	always_ff @(posedge clk) begin
		if (rst) begin
			rdy_dly  <= '0;
			win      <= '1;
			zero_cnt <= '0;
			ff_cnt   <= '0;
		end else begin
			rdy_dly <= {rdy_dly[0], rx_rdy};

			if (cmd_valid) begin
				win <= '1;  // all 0xff can never pass for a preamble again
			end else if (rdy_dly[1] && idle) begin
				win <= {win[14:0], rx_data};

				// count what drops out of the oldest slot
				case (win[15])
					8'h00: begin
						if (ff_cnt != '0)
							zero_cnt <= 3'd1;  // a new preamble after stale 0xff bytes
						else if (zero_cnt != 3'd7)
							zero_cnt <= zero_cnt + 3'd1;
						ff_cnt <= '0;
					end
					8'hff: begin
						if (ff_cnt != 3'd7)
							ff_cnt <= ff_cnt + 3'd1;  // zero count holds across the 0xff run
					end
					default: begin
						zero_cnt <= '0;
						ff_cnt   <= '0;
					end
				endcase
			end
		end
	end

endmodule

// ==== src/xfer_engine.sv ====
`timescale 1ns/1ps

module xfer_engine import dbg_pkg::*; #(
	parameter int         rd_latency   = 4,
	parameter int         timeout_bits = 24,
	parameter host_addr_t rst_addr     = '0
) (
	input  logic       clk,
	input  logic       rst,
	input  dbg_cmd_t   cmd,
	input  logic       cmd_valid,
	input  byte_t      rx_data,
	input  logic       rx_rdy,
	input  logic       tx_busy,
	input  byte_t      host_rdata,
	input  port_word_t gp_in,
	output logic       idle,
	output logic       tx_start,
	output byte_t      tx_data,
	output host_req_t  host,
	output port_word_t gp_out
);

	// rd_req is on the bus in cycle 1, the data is taken rd_latency cycles later
	localparam logic [3:0] rd_sample = 4'(rd_latency + 1);

	xfer_state_t           state;
	count_t                xfer_cnt;    // bytes left minus one
	logic [3:0]            cyc;         // step within the 16-cycle byte slot
	logic [timeout_bits:0] rx_timeout;  // msb set means the host went quiet
	logic [2:0]            rdy_dly;     // rx_rdy delayed by one, two and three cycles
	logic                  rd_req;
	logic                  wr_ena;
	host_addr_t            addr;
	byte_t                 wdata;
	port_word_t            in_reg;      // gp_in as seen when SetP arrived

	assign idle = (state == st_idle);
	assign host = '{rd_req: rd_req, wr_ena: wr_ena, addr: addr, wdata: wdata};

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= st_idle;
			xfer_cnt   <= '1;
			cyc        <= '0;
			rx_timeout <= '0;
			rdy_dly    <= '0;
			rd_req     <= 1'b0;
			wr_ena     <= 1'b0;
			tx_start   <= 1'b0;
			addr       <= rst_addr;
			gp_out     <= '0;
		end else begin
			rdy_dly  <= {rdy_dly[1:0], rx_rdy};
			rd_req   <= 1'b0;  // all strobes are single cycle
			wr_ena   <= 1'b0;
			tx_start <= 1'b0;

			case (state)
				st_idle: begin
					if (cmd_valid) begin
						xfer_cnt <= {1'b0, cmd.count};
						cyc      <= '0;
						if (cmd.op == op_read) begin
							addr  <= cmd.addr;
							state <= st_read;
						end else if (cmd.op == op_write) begin
							addr       <= cmd.addr;
							rx_timeout <= '0;
							state      <= st_write;
						end else begin
							gp_out   <= {cmd.addr, cmd.count};  // body bytes 4 to 7 are ports 0 to 3
							in_reg   <= gp_in;
							xfer_cnt <= 9'd3;  // four port bytes
							state    <= st_ports;
						end
					end
				end

				// ************************************************************************
				// read and port return share the 16-cycle slot per byte
				// ************************************************************************
				st_read, st_ports: begin
					if (xfer_cnt[8]) begin
						state <= st_idle;
					end else if (!(tx_busy && cyc == '0)) begin  // wait only at the slot start
						cyc <= cyc + 4'd1;
						if (state == st_read && cyc == '0)
							rd_req <= 1'b1;
						if (cyc == rd_sample) begin
							if (state == st_read)
								tx_data <= host_rdata;
							else
								tx_data <= in_reg[8 * xfer_cnt[1:0] +: 8];  // port 0 goes first
						end
						if (cyc == 4'd14)
							tx_start <= 1'b1;
						if (cyc == 4'd15) begin
							xfer_cnt <= xfer_cnt - 9'd1;
							if (state == st_read)
								addr <= addr + 1'b1;
						end
					end
				end

				// ************************************************************************
				// write each received byte to the host and echo it back
				// ************************************************************************
				st_write: begin
					if (xfer_cnt[8] || rx_timeout[timeout_bits]) begin
						state <= st_idle;  // done, or the rest of the data never came
					end else begin
						if (rx_rdy)
							rx_timeout <= '0;
						else
							rx_timeout <= rx_timeout + 1'b1;
						if (rdy_dly[0]) begin
							wdata    <= rx_data;
							tx_data  <= rx_data;
							wr_ena   <= 1'b1;
							tx_start <= 1'b1;
						end
						if (rdy_dly[2]) begin  // two cycles after the write strobe
							addr     <= addr + 1'b1;
							xfer_cnt <= xfer_cnt - 9'd1;
						end
					end
				end

				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== src/rs232_debugger.sv ====
`timescale 1ns/1ps

module rs232_debugger import dbg_pkg::*; #(
	parameter int         bit_clks     = 54,   // clock cycles per serial bit
	parameter int         rd_latency   = 4,    // host read data delay after rd_req, 13 at most
	parameter int         timeout_bits = 24,   // Writ gives up after 2^timeout_bits quiet cycles
	parameter host_addr_t rst_addr     = '0
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       rxd,
	output logic       txd,
	output host_req_t  host,
	input  byte_t      host_rdata,
	input  port_word_t gp_in,
	output port_word_t gp_out
);

	byte_t    rx_data;
	logic     rx_rdy;
	logic     rx_trigger;  // start edge seen by the receiver
	logic     tx_start;
	byte_t    tx_data;
	logic     tx_busy;
	dbg_cmd_t cmd;
	logic     cmd_valid;
	logic     idle;        // engine free, the detector may take bytes

	uart_rx #(
		.bit_clks(bit_clks)
	) uart_rx_i (
		.clk(clk),
		.rst(rst),
		.rxd(rxd),
		.rx_data(rx_data),
		.rx_rdy(rx_rdy),
		.rx_trigger(rx_trigger)
	);

	uart_tx #(
		.bit_clks(bit_clks)
	) uart_tx_i (
		.clk(clk),
		.rst(rst),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.rx_trigger(rx_trigger),
		.txd(txd),
		.tx_busy(tx_busy)
	);

	cmd_detect cmd_detect_i (
		.clk(clk),
		.rst(rst),
		.rx_data(rx_data),
		.rx_rdy(rx_rdy),
		.idle(idle),
		.cmd(cmd),
		.cmd_valid(cmd_valid)
	);

	xfer_engine #(
		.rd_latency(rd_latency),
		.timeout_bits(timeout_bits),
		.rst_addr(rst_addr)
	) xfer_engine_i (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.rx_data(rx_data),
		.rx_rdy(rx_rdy),
		.tx_busy(tx_busy),
		.host_rdata(host_rdata),
		.gp_in(gp_in),
		.idle(idle),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.host(host),
		.gp_out(gp_out)
	);

endmodule

// ==== test/tb_rs232_debugger.sv ====
`timescale 1ns/1ps

module tb_rs232_debugger import dbg_pkg::*;;

	localparam int         bit_clks     = 16;
	localparam int         rd_latency   = 4;
	localparam int         timeout_bits = 12;
	localparam host_addr_t rst_addr     = '0;

	logic       clk = 1'b0;
	logic       rst = 1'b1;
	logic       rxd = 1'b1;   // serial line idles high
	logic       txd;
	host_req_t  host;
	byte_t      host_rdata = '0;
	port_word_t gp_in = '0;
	port_word_t gp_out;

	byte_t       mem [256];      // host memory model, indexed by the low address byte
	byte_t       exp_mem [256];  // what the memory should hold after each command
	byte_t       rx_q [$];       // bytes seen on txd
	logic [31:0] wr_exp_q [$];   // expected writes as {addr, data}
	int          errors = 0;
	int          timeouts = 0;
	int          strobes = 0;    // rd_req and wr_ena pulses seen so far
	int          rd_cnt = 0;     // cycles left until the read data is driven
	byte_t       rd_addr;
	logic [31:0] lcg_state = 32'd16;

	rs232_debugger #(
		.bit_clks(bit_clks), .rd_latency(rd_latency),
		.timeout_bits(timeout_bits), .rst_addr(rst_addr)
	) rs232_debugger_i (
		.clk(clk), .rst(rst), .rxd(rxd), .txd(txd), .host(host),
		.host_rdata(host_rdata), .gp_in(gp_in), .gp_out(gp_out)
	);

	always #4 clk = ~clk;

	function automatic byte_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];  // the upper bits are the least regular ones
	endfunction

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ************************************************************************
	// host bus model, reads answer rd_latency cycles after the strobe
	// ************************************************************************
	always @(negedge clk) begin
		logic [31:0] w;
		if (!rst) begin
			if (rd_cnt != 0) begin
				rd_cnt--;
				if (rd_cnt == 0)
					host_rdata <= mem[rd_addr];
			end
			if (host.rd_req) begin
				strobes++;
				rd_cnt  = rd_latency;
				rd_addr = host.addr[7:0];
			end
			if (host.wr_ena) begin
				strobes++;
				if (wr_exp_q.size() == 0) begin
					errors++;
					$display("unexpected host write to %h at %0t ns", host.addr, $time);
				end else begin
					w = wr_exp_q.pop_front();
					check_value("write address", 32'(host.addr), 32'(w[31:8]));
					check_value("write data", 32'(host.wdata), 32'(w[7:0]));
				end
				mem[host.addr[7:0]] = host.wdata;
			end
		end
	end

	// serial receiver on txd, samples each bit in its middle
	always begin
		byte_t b;
		@(negedge clk);
		if (!rst && txd == 1'b0) begin
			repeat (bit_clks / 2) @(negedge clk);
			if (txd == 1'b0) begin
				for (int i = 0; i < 8; i++) begin
					repeat (bit_clks) @(negedge clk);
					b[i] = txd;  // lsb first
				end
				repeat (bit_clks) @(negedge clk);
				check_value("stop bit", 32'(txd), 32'd1);
				rx_q.push_back(b);
			end
		end
	end

	task automatic send_byte(input byte_t b);
		logic [9:0] f;
		f = {1'b1, b, 1'b0};
		for (int i = 0; i < 12; i++) begin  // two idle bits after the stop bit
			rxd = (i < 10) ? f[i] : 1'b1;
			repeat (bit_clks) @(negedge clk);
		end
	endtask

	task automatic send_frame(input dbg_cmd_t body, input dbg_cmd_t copy);
		repeat (pre_zero_cnt) send_byte(8'h00);
		repeat (pre_ff_cnt) send_byte(8'hff);
		for (int i = 7; i >= 0; i--) send_byte(body[8 * i +: 8]);  // opcode first
		for (int i = 7; i >= 0; i--) send_byte(copy[8 * i +: 8]);
	endtask

	task automatic wait_rx(input int n);
		int limit;
		limit = n * bit_clks * 14 + 2000;
		for (int c = 0; rx_q.size() < n; c++) begin
			if (c > limit) begin
				timeouts++;
				$display("timeout: only %0d of %0d bytes came back on txd", rx_q.size(), n);
				break;
			end
			@(negedge clk);
		end
		repeat (bit_clks * 12) @(negedge clk);  // let any extra byte show up
		check_value("returned byte count", rx_q.size(), n);
	endtask

	initial begin
		int fd, kind, n, nsent, s0;
		string line;
		logic [31:0] va, vc, vs, vgi, vgo;
		byte_t d [$];
		for (int i = 0; i < 256; i++) begin
			mem[i] = byte_t'(i * 7 + 3);  // every address gets its own value
			exp_mem[i] = mem[i];
		end
		repeat (10) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < 100; i++) begin  // quiet line and bus after reset
			@(negedge clk);
			check_value("txd after reset", 32'(txd), 32'd1);
		end
		check_value("strobes after reset", strobes, 0);
		fd = $fopen("test/debug_vectors.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open test/debug_vectors.txt");
		end
		while (fd != 0 && !$feof(fd)) begin
			if ($fgets(line, fd) == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			void'($sscanf(line, "%h %h %h %h %h %h", kind, va, vc, vs, vgi, vgo));
			n = vc[7:0] + 1;
			nsent = vs;
			rx_q.delete();
			case (kind)
				1: begin  // Writ with echo
					d.delete();
					for (int i = 0; i < nsent; i++) begin
						d.push_back(lcg_next());
						wr_exp_q.push_back({va[23:0] + 24'(i), d[i]});
						exp_mem[byte_t'(va + i)] = d[i];
					end
					send_frame({op_write, va[23:0], vc[7:0]}, {op_write, va[23:0], vc[7:0]});
					foreach (d[i]) send_byte(d[i]);
					wait_rx(nsent);
					foreach (d[i]) if (i < rx_q.size()) check_value("echo", rx_q[i], d[i]);
					if (nsent < n) repeat ((1 << timeout_bits) + 500) @(negedge clk);
					check_value("missing writes", wr_exp_q.size(), 0);
				end
				2: begin  // Read
					send_frame({op_read, va[23:0], vc[7:0]}, {op_read, va[23:0], vc[7:0]});
					wait_rx(n);
					for (int i = 0; i < n && i < rx_q.size(); i++)
						check_value("read data", rx_q[i], exp_mem[byte_t'(va + i)]);
				end
				3: begin  // SetP
					gp_in = vgi;
					send_frame({op_setp, va[23:0], vc[7:0]}, {op_setp, va[23:0], vc[7:0]});
					gp_in = ~vgi;  // the returned bytes come from the copy taken with the command
					wait_rx(4);
					check_value("gp_out", gp_out, vgo);
					for (int i = 0; i < 4 && i < rx_q.size(); i++)
						check_value("port byte", rx_q[i], vgi[31 - 8 * i -: 8]);  // port 0 first
				end
				default: begin  // body copies differ, nothing may happen
					s0 = strobes;
					send_frame({op_read, va[23:0], vc[7:0]}, {op_read, va[23:0], vc[7:0] ^ 8'h01});
					repeat (bit_clks * 40) @(negedge clk);
					check_value("strobes on a bad frame", strobes, s0);
					check_value("bytes on a bad frame", rx_q.size(), 0);
				end
			endcase
			repeat (100) @(negedge clk);
		end
		if (fd != 0) $fclose(fd);
		for (int i = 0; i < 256; i++) check_value("memory contents", mem[i], exp_mem[i]);
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== test/debug_vectors.txt ====
# kind addr count nsent gp_in gp_out, all hex
# kind 1 Writ, 2 Read, 3 SetP, 4 frame with differing body copies
1 000010 07 08 0 0
2 000010 07 08 0 0
3 a1b2c3 d4 0 11223344 a1b2c3d4
4 000040 03 04 0 0
2 00000e 0b 0c 0 0
1 000080 09 04 0 0
2 00007e 07 08 0 0
3 5a0f00 ff 0 deadbeef 5a0f00ff

// ==== tb.f ====
src/dbg_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_detect.sv
src/xfer_engine.sv
src/rs232_debugger.sv
test/tb_rs232_debugger.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rs232_debugger
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f tb.f --top-module $(TOP) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
